// ==== pf_macros.svh ====
// Prefetch controller constants

`ifndef PF_MACROS_SVH
`define PF_MACROS_SVH

//////////////////////////////
// Fetch FIFO sizing
//////////////////////////////

// FIFO depth and cap on outstanding transactions
`define PF_DEPTH 4

// Width of every count, clog2 of depth plus one
`define PF_CNT_W 3

//////////////////////////////
// Addressing
//////////////////////////////

// Instruction bus address width
`define PF_ADDR_W 32

// Byte step between sequential prefetch words
`define PF_WORD_BYTES 4

`endif

// ==== pf_pkg.sv ====
// Prefetch controller types

`default_nettype none

`include "pf_macros.svh"

package pf_pkg;

  //////////////////////////////
  // Issue FSM
  //////////////////////////////

  // Branch-wait holds a target until the bus accepts it
  typedef enum logic {
    PF_IDLE        = 1'b0,
    PF_BRANCH_WAIT = 1'b1
  } pf_state_e;

  //////////////////////////////
  // Fetch stage request
  //////////////////////////////

  typedef struct packed {
    logic                  req;          // Fetch wanted
    logic                  branch;       // Taken branch
    logic [`PF_ADDR_W-1:0] branch_addr;  // Valid with branch only
    logic                  hwlp_jump;    // Hardware-loop jump
    logic [`PF_ADDR_W-1:0] hwlp_target;  // Loop start address
  } fetch_req_t;

  //////////////////////////////
  // Fetch FIFO command
  //////////////////////////////

  typedef struct packed {
    logic push;
    logic pop;
    logic flush;
    logic flush_but_first;
  } fifo_ctrl_t;

endpackage

`default_nettype wire

// ==== pf_trans_issue.sv ====
// Transaction request generator

`timescale 1ns/1ns
`default_nettype none

`include "pf_macros.svh"

module pf_trans_issue (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // Control flow from the fetch stage
  input  wire pf_pkg::fetch_req_t    fetch_req_i,
  // Bus adapter request handshake
  input  wire logic                  trans_ready_i,
  // Fill level of the fetch FIFO
  input  wire logic [`PF_CNT_W-1:0]  fifo_cnt_i,
  // Outstanding transactions from the response side
  input  wire logic [`PF_CNT_W-1:0]  out_cnt_i,
  output logic                       trans_valid_o,
  output logic [`PF_ADDR_W-1:0]      trans_addr_o,
  output logic                       trans_accept_o,
  output logic                       busy_o
);

  // Byte step of the sequential address
  localparam logic [`PF_ADDR_W-1:0] addr_step = `PF_WORD_BYTES;

  pf_pkg::pf_state_e state_q;
  pf_pkg::pf_state_e state_d;

  // Last issued or pending target
  logic [`PF_ADDR_W-1:0] addr_q;

  logic                  redirect;
  logic [`PF_ADDR_W-1:0] branch_aligned;
  logic [`PF_CNT_W-1:0]  fifo_cnt_masked;
  // One bit wider so the sum cannot wrap
  logic [`PF_CNT_W:0]    fill_sum;

  //////////////////////////////
  // Request valid
  //////////////////////////////

  assign redirect = fetch_req_i.branch || fetch_req_i.hwlp_jump;

  // FIFO contents are about to be flushed on a redirect
  assign fifo_cnt_masked = redirect ? '0 : fifo_cnt_i;

  assign fill_sum = {1'b0, fifo_cnt_masked} + {1'b0, out_cnt_i};

  // Never more in flight than the FIFO can still take
  assign trans_valid_o = fetch_req_i.req && (fill_sum < `PF_DEPTH);

  assign trans_accept_o = trans_valid_o && trans_ready_i;

  assign busy_o = (out_cnt_i != '0) || trans_valid_o;

  //////////////////////////////
  // Address select
  //////////////////////////////

  // Targets are fetched as whole words
  assign branch_aligned = {fetch_req_i.branch_addr[`PF_ADDR_W-1:2], 2'b00};

  always_comb begin
    trans_addr_o = addr_q;
    if (state_q == pf_pkg::PF_BRANCH_WAIT) begin
      // Replay the held target, a newer branch replaces it
      if (fetch_req_i.branch) begin
        trans_addr_o = branch_aligned;
      end
    end else if (fetch_req_i.branch) begin
      trans_addr_o = branch_aligned;
    end else if (fetch_req_i.hwlp_jump) begin
      trans_addr_o = fetch_req_i.hwlp_target;
    end else begin
      // Next sequential word
      trans_addr_o = {addr_q[`PF_ADDR_W-1:2], 2'b00} + addr_step;
    end
  end

  //////////////////////////////
  // Branch-wait FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    if (trans_accept_o) begin
      state_d = pf_pkg::PF_IDLE;
    end else if (redirect) begin
      // Target not taken by the bus yet
      state_d = pf_pkg::PF_BRANCH_WAIT;
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= pf_pkg::PF_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (redirect || trans_accept_o) begin
        addr_q <= trans_addr_o;
      end
    end
  end

endmodule

`default_nettype wire

// ==== pf_resp_flush_ctrl.sv ====
// Response flush and FIFO steering

`timescale 1ns/1ns
`default_nettype none

`include "pf_macros.svh"

module pf_resp_flush_ctrl (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // Control flow from the fetch stage
  input  wire pf_pkg::fetch_req_t    fetch_req_i,
  // Request accepted by the bus this cycle
  input  wire logic                  trans_accept_i,
  // Bus response, always consumed
  input  wire logic                  resp_valid_i,
  // Fetch stage handshake
  input  wire logic                  fetch_ready_i,
  input  wire logic                  fifo_empty_i,
  output logic [`PF_CNT_W-1:0]       out_cnt_o,
  output logic                       fetch_valid_o,
  output pf_pkg::fifo_ctrl_t         fifo_ctrl_o
);

  // Outstanding transaction count
  logic [`PF_CNT_W-1:0] out_cnt_q;
  logic [`PF_CNT_W-1:0] out_cnt_d;

  // Responses still to be discarded
  logic [`PF_CNT_W-1:0] flush_cnt_q;
  logic [`PF_CNT_W-1:0] flush_cnt_d;

  // Delayed flush waiting for the loop-end word
  logic                 hwlp_armed_q;
  logic [`PF_CNT_W-1:0] hwlp_saved_cnt_q;

  logic fifo_valid;
  logic flush_active;
  logic pop;
  logic hwlp_flush_now;
  logic hwlp_wait_resp;
  logic hwlp_fire;

  //////////////////////////////
  // FIFO steering
  //////////////////////////////

  assign fifo_valid = !fifo_empty_i;

  // Nothing reaches the fetch stage while jumping or discarding
  assign flush_active = fetch_req_i.branch || (flush_cnt_q != '0);

  // FIFO word or the bypassing response
  assign fetch_valid_o = (fifo_valid || resp_valid_i) && !flush_active;

  assign pop = fifo_valid && fetch_ready_i;

  // Response goes into the FIFO unless it bypasses straight to fetch
  assign fifo_ctrl_o.push = resp_valid_i && (fifo_valid || !fetch_ready_i) && !flush_active;
  assign fifo_ctrl_o.pop  = pop;

  // Loop jump keeps the head word unless it leaves this cycle
  assign fifo_ctrl_o.flush = fetch_req_i.branch ||
                             (fetch_req_i.hwlp_jump && fifo_valid && pop);
  assign fifo_ctrl_o.flush_but_first = fetch_req_i.hwlp_jump && fifo_valid && !pop;

  //////////////////////////////
  // Outstanding counter
  //////////////////////////////

  // Accept and response together cancel out
  always_comb begin
    case ({trans_accept_i, resp_valid_i})
      2'b10: begin
        out_cnt_d = out_cnt_q + 1'b1;
      end
      2'b01: begin
        out_cnt_d = out_cnt_q - 1'b1;
      end
      default: begin
        out_cnt_d = out_cnt_q;
      end
    endcase
  end

  assign out_cnt_o = out_cnt_q;

  //////////////////////////////
  // Hardware-loop flush
  //////////////////////////////

  // Loop-end word already here or arriving, flush right away
  assign hwlp_flush_now = fetch_req_i.hwlp_jump && !(fifo_empty_i && !resp_valid_i);

  // Loop-end word still on the bus, wait for it
  assign hwlp_wait_resp = fetch_req_i.hwlp_jump && fifo_empty_i && !resp_valid_i;

  // First response after arming is the loop-end word
  assign hwlp_fire = hwlp_armed_q && resp_valid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hwlp_armed_q     <= 1'b0;
      hwlp_saved_cnt_q <= '0;
    end else if (fetch_req_i.branch) begin
      // Branch wins over a pending loop flush
      hwlp_armed_q     <= 1'b0;
      hwlp_saved_cnt_q <= '0;
    end else if (hwlp_wait_resp) begin
      hwlp_armed_q     <= 1'b1;
      // Everything after the loop-end word is stale
      hwlp_saved_cnt_q <= out_cnt_q - 1'b1;
    end else if (hwlp_fire) begin
      hwlp_armed_q     <= 1'b0;
      hwlp_saved_cnt_q <= '0;
    end
  end

  //////////////////////////////
  // Flush counter
  //////////////////////////////

  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (fetch_req_i.branch || hwlp_flush_now) begin
      // All in-flight words are wrong path
      flush_cnt_d = out_cnt_q;
      // A response this cycle is dropped already
      if (resp_valid_i && (out_cnt_q != '0)) begin
        flush_cnt_d = out_cnt_q - 1'b1;
      end
    end else if (hwlp_fire) begin
      flush_cnt_d = hwlp_saved_cnt_q;
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      // One stale response discarded
      flush_cnt_d = flush_cnt_q - 1'b1;
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q   <= '0;
      flush_cnt_q <= '0;
    end else begin
      out_cnt_q   <= out_cnt_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

endmodule

`default_nettype wire

// ==== prefetch_ctrl_top.sv ====
// Instruction prefetch controller

`timescale 1ns/1ns
`default_nettype none

`include "pf_macros.svh"

module prefetch_ctrl_top (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // Fetch stage
  input  wire pf_pkg::fetch_req_t    fetch_req_i,
  input  wire logic                  fetch_ready_i,
  output logic                       fetch_valid_o,
  // Bus adapter
  output logic                       trans_valid_o,
  input  wire logic                  trans_ready_i,
  output logic [`PF_ADDR_W-1:0]      trans_addr_o,
  input  wire logic                  resp_valid_i,
  // Fetch FIFO
  output pf_pkg::fifo_ctrl_t         fifo_ctrl_o,
  input  wire logic [`PF_CNT_W-1:0]  fifo_cnt_i,
  input  wire logic                  fifo_empty_i,
  // Activity status
  output logic                       busy_o
);

  //////////////////////////////
  // Internal links
  //////////////////////////////

  // Request accepted by the bus
  logic                 trans_accept;
  // Transactions still waiting for a response
  logic [`PF_CNT_W-1:0] out_cnt;

  // Request side
  pf_trans_issue pf_trans_issue_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_req_i    (fetch_req_i),
    .trans_ready_i  (trans_ready_i),
    .fifo_cnt_i     (fifo_cnt_i),
    .out_cnt_i      (out_cnt),
    .trans_valid_o  (trans_valid_o),
    .trans_addr_o   (trans_addr_o),
    .trans_accept_o (trans_accept),
    .busy_o         (busy_o)
  );

  // Response side and FIFO control
  pf_resp_flush_ctrl pf_resp_flush_ctrl_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_req_i    (fetch_req_i),
    .trans_accept_i (trans_accept),
    .resp_valid_i   (resp_valid_i),
    .fetch_ready_i  (fetch_ready_i),
    .fifo_empty_i   (fifo_empty_i),
    .out_cnt_o      (out_cnt),
    .fetch_valid_o  (fetch_valid_o),
    .fifo_ctrl_o    (fifo_ctrl_o)
  );

endmodule

`default_nettype wire

// ==== pf_checker.sv ====
// Prefetch controller output checker

`timescale 1ns/1ns
`default_nettype none

`include "pf_macros.svh"

module pf_checker #(
  // Sample point after the rising edge, just before the next one
  parameter int sample_delay = 9
) (
  input  wire logic                  clk,
  input  wire logic                  check_en_i,
  // DUT outputs
  input  wire logic                  trans_valid_i,
  input  wire logic [`PF_ADDR_W-1:0] trans_addr_i,
  input  wire logic                  fetch_valid_i,
  input  wire pf_pkg::fifo_ctrl_t    fifo_ctrl_i,
  input  wire logic                  busy_i,
  // Expected values from the trace
  input  wire logic                  exp_trans_valid_i,
  input  wire logic [`PF_ADDR_W-1:0] exp_trans_addr_i,
  input  wire logic                  exp_fetch_valid_i,
  input  wire pf_pkg::fifo_ctrl_t    exp_fifo_ctrl_i,
  input  wire logic                  exp_busy_i,
  // Running totals
  output int                         check_cnt_o,
  output int                         error_cnt_o
);

  int checks = 0;
  int errors = 0;

  assign check_cnt_o = checks;
  assign error_cnt_o = errors;

  //////////////////////////////
  // Comparison
  //////////////////////////////

  // X or Z on the DUT side counts as wrong
  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    #(sample_delay);
    if (check_en_i) begin
      checks++;
      compare_field("trans_valid_o", {31'b0, trans_valid_i}, {31'b0, exp_trans_valid_i});
      // Address only meaningful with a valid request
      if (exp_trans_valid_i) begin
        compare_field("trans_addr_o", trans_addr_i, exp_trans_addr_i);
      end
      compare_field("fetch_valid_o", {31'b0, fetch_valid_i}, {31'b0, exp_fetch_valid_i});
      compare_field("fifo_ctrl_o", {28'b0, fifo_ctrl_i}, {28'b0, exp_fifo_ctrl_i});
      compare_field("busy_o", {31'b0, busy_i}, {31'b0, exp_busy_i});
    end
  end

endmodule

`default_nettype wire

// ==== prefetch_ctrl_tb.sv ====
// Prefetch controller testbench

`timescale 1ns/1ns
`default_nettype none

`include "pf_macros.svh"

module prefetch_ctrl_tb;

  localparam int clk_period   = 10;
  localparam int reset_cycles = 4;
  localparam int drive_delay  = 1;
  localparam int margin_ns    = 200;
  localparam int num_cols     = 14;

  // Stimulus of one trace line
  typedef struct packed {
    pf_pkg::fetch_req_t   fetch_req;
    logic                 trans_ready;
    logic                 resp_valid;
    logic                 fetch_ready;
    logic [`PF_CNT_W-1:0] fifo_cnt;
  } stim_t;

  // Expected outputs of the same line
  typedef struct packed {
    logic                  trans_valid;
    logic [`PF_ADDR_W-1:0] trans_addr;
    logic                  fetch_valid;
    pf_pkg::fifo_ctrl_t    fifo_ctrl;
    logic                  busy;
  } expect_t;

  logic                  clk;
  logic                  rst_n;
  pf_pkg::fetch_req_t    fetch_req;
  logic                  fetch_ready;
  logic                  trans_ready;
  logic                  resp_valid;
  logic [`PF_CNT_W-1:0]  fifo_cnt;
  logic                  fifo_empty;
  logic                  fetch_valid;
  logic                  trans_valid;
  logic [`PF_ADDR_W-1:0] trans_addr;
  pf_pkg::fifo_ctrl_t    fifo_ctrl;
  logic                  busy;

  // Expected values handed to the checker
  expect_t exp_cur;
  logic    check_en;
  int      check_cnt;
  int      error_cnt;

  stim_t   stim_q[$];
  expect_t exp_q[$];
  int      num_lines;
  int      load_errors;
  bit      trace_loaded;

  //////////////////////////////
  // Clock
  //////////////////////////////

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  //////////////////////////////
  // DUT and checker
  //////////////////////////////

  prefetch_ctrl_top prefetch_ctrl_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req_i   (fetch_req),
    .fetch_ready_i (fetch_ready),
    .fetch_valid_o (fetch_valid),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_addr_o  (trans_addr),
    .resp_valid_i  (resp_valid),
    .fifo_ctrl_o   (fifo_ctrl),
    .fifo_cnt_i    (fifo_cnt),
    .fifo_empty_i  (fifo_empty),
    .busy_o        (busy)
  );

  pf_checker pf_checker_inst (
    .clk               (clk),
    .check_en_i        (check_en),
    .trans_valid_i     (trans_valid),
    .trans_addr_i      (trans_addr),
    .fetch_valid_i     (fetch_valid),
    .fifo_ctrl_i       (fifo_ctrl),
    .busy_i            (busy),
    .exp_trans_valid_i (exp_cur.trans_valid),
    .exp_trans_addr_i  (exp_cur.trans_addr),
    .exp_fetch_valid_i (exp_cur.fetch_valid),
    .exp_fifo_ctrl_i   (exp_cur.fifo_ctrl),
    .exp_busy_i        (exp_cur.busy),
    .check_cnt_o       (check_cnt),
    .error_cnt_o       (error_cnt)
  );

  //////////////////////////////
  // Trace handling
  //////////////////////////////

  // Comment and blank lines are skipped
  task automatic load_trace();
    int          fd;
    int          line_no;
    int          n;
    string       line;
    logic [31:0] col [num_cols];
    stim_t       s;
    expect_t     e;
    fd = $fopen("prefetch_ctrl_trace.txt", "r");
    if (fd == 0) begin
      $display("error: could not open prefetch_ctrl_trace.txt");
      load_errors++;
      return;
    end
    line_no = 0;
    while ($fgets(line, fd) != 0) begin
      line_no++;
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                  col[7], col[8], col[9], col[10], col[11], col[12], col[13]);
      if (n != num_cols) begin
        $display("error: trace line %0d holds %0d fields instead of %0d", line_no, n, num_cols);
        load_errors++;
        continue;
      end
      s.fetch_req.req         = col[0][0];
      s.fetch_req.branch      = col[1][0];
      s.fetch_req.branch_addr = col[2];
      s.fetch_req.hwlp_jump   = col[3][0];
      s.fetch_req.hwlp_target = col[4];
      s.trans_ready           = col[5][0];
      s.resp_valid            = col[6][0];
      s.fetch_ready           = col[7][0];
      s.fifo_cnt              = col[8][`PF_CNT_W-1:0];
      e.trans_valid           = col[9][0];
      e.trans_addr            = col[10];
      e.fetch_valid           = col[11][0];
      // Nibble order push, pop, flush, flush_but_first
      e.fifo_ctrl             = col[12][3:0];
      e.busy                  = col[13][0];
      stim_q.push_back(s);
      exp_q.push_back(e);
    end
    $fclose(fd);
  endtask

  // Empty flag follows the fill level
  task automatic apply_line(input stim_t s, input expect_t e);
    fetch_req   = s.fetch_req;
    trans_ready = s.trans_ready;
    resp_valid  = s.resp_valid;
    fetch_ready = s.fetch_ready;
    fifo_cnt    = s.fifo_cnt;
    fifo_empty  = (s.fifo_cnt == '0);
    exp_cur     = e;
    check_en    = 1'b1;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : main
    rst_n        = 1'b0;
    fetch_req    = '0;
    fetch_ready  = 1'b0;
    trans_ready  = 1'b0;
    resp_valid   = 1'b0;
    fifo_cnt     = '0;
    fifo_empty   = 1'b1;
    exp_cur      = '0;
    check_en     = 1'b0;
    load_errors  = 0;
    trace_loaded = 1'b0;
    load_trace();
    num_lines = stim_q.size();
    if (num_lines == 0 && load_errors == 0) begin
      $display("error: trace holds no data lines");
      load_errors++;
    end
    trace_loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    rst_n = 1'b1;
    // One trace line per cycle
    for (int i = 0; i < num_lines; i++) begin
      @(posedge clk);
      #(drive_delay);
      apply_line(stim_q[i], exp_q[i]);
    end
    @(posedge clk);
    #(drive_delay);
    check_en = 1'b0;
    $display("checks: %0d  mismatches: %0d  trace errors: %0d",
             check_cnt, error_cnt, load_errors);
    if (error_cnt == 0 && load_errors == 0 && check_cnt == num_lines) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog sized from the trace length
  initial begin : watchdog
    wait (trace_loaded);
    #(num_lines * clk_period + margin_ns);
    $display("timeout: the run did not finish within %0d ns",
             num_lines * clk_period + margin_ns);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== prefetch_ctrl_trace.txt ====
# in:  req branch branch_addr hwlp_jump hwlp_target trans_ready resp_valid fetch_ready fifo_cnt
# out: trans_valid trans_addr fetch_valid fifo_ctrl(push,pop,flush,flush_but_first) busy
0 0 00000000 0 00000000 0 0 0 0   0 00000000 0 0 0
1 1 00001002 0 00000000 1 0 1 0   1 00001000 0 2 1
1 0 00000000 0 00000000 1 0 1 0   1 00001004 0 0 1
1 0 00000000 0 00000000 1 1 1 0   1 00001008 1 0 1
1 0 00000000 0 00000000 1 1 0 0   1 0000100c 1 8 1
1 0 00000000 0 00000000 1 1 0 1   1 00001010 1 8 1
# overflow guard and busy
1 0 00000000 0 00000000 1 0 0 2   0 00000000 1 0 1
1 0 00000000 0 00000000 1 1 0 2   0 00000000 1 8 1
1 0 00000000 0 00000000 1 0 0 3   0 00000000 1 0 1
1 0 00000000 0 00000000 1 0 1 3   0 00000000 1 4 1
1 0 00000000 0 00000000 1 0 1 2   1 00001014 1 4 1
1 0 00000000 0 00000000 1 1 1 1   1 00001018 1 c 1
1 0 00000000 0 00000000 1 1 1 1   1 0000101c 1 c 1
1 0 00000000 0 00000000 1 1 1 1   1 00001020 1 c 1
0 0 00000000 0 00000000 1 1 1 1   0 00000000 1 c 1
0 0 00000000 0 00000000 1 1 1 1   0 00000000 1 c 1
0 0 00000000 0 00000000 1 0 1 1   0 00000000 1 4 0
0 0 00000000 0 00000000 0 0 1 0   0 00000000 0 0 0
# branch under back-pressure, second branch replaces the first
1 1 00002003 0 00000000 0 0 1 0   1 00002000 0 2 1
1 0 00000000 0 00000000 0 0 1 0   1 00002000 0 0 1
1 1 00003006 0 00000000 0 0 1 0   1 00003004 0 2 1
1 0 00000000 0 00000000 0 0 1 0   1 00003004 0 0 1
1 0 00000000 0 00000000 1 0 1 0   1 00003004 0 0 1
1 0 00000000 0 00000000 1 0 1 0   1 00003008 0 0 1
1 0 00000000 0 00000000 1 0 1 0   1 0000300c 0 0 1
# speculative flush after a branch with three outstanding
1 1 00004000 0 00000000 1 1 1 0   1 00004000 0 2 1
1 0 00000000 0 00000000 1 1 1 0   1 00004004 0 0 1
1 0 00000000 0 00000000 0 1 1 0   1 00004008 0 0 1
1 0 00000000 0 00000000 0 1 1 0   1 00004008 1 0 1
1 0 00000000 0 00000000 1 1 1 0   1 00004008 1 0 1
0 0 00000000 0 00000000 1 1 1 0   0 00000000 1 0 1
0 0 00000000 0 00000000 0 0 1 0   0 00000000 0 0 0
# hardware-loop jump with a nonempty FIFO
1 0 00000000 0 00000000 1 0 0 0   1 0000400c 0 0 1
1 0 00000000 0 00000000 1 1 0 0   1 00004010 1 8 1
1 0 00000000 0 00000000 1 0 0 1   1 00004014 1 0 1
1 0 00000000 1 00005000 1 0 0 1   1 00005000 1 1 1
1 0 00000000 0 00000000 1 1 0 1   0 00000000 0 0 1
1 0 00000000 0 00000000 1 1 0 1   1 00005004 0 0 1
1 0 00000000 0 00000000 0 1 1 1   1 00005008 1 c 1
1 0 00000000 1 00006000 1 0 1 1   1 00006000 1 6 1
0 0 00000000 0 00000000 1 1 1 0   0 00000000 0 0 1
0 0 00000000 0 00000000 1 1 1 0   0 00000000 1 0 1
0 0 00000000 0 00000000 0 0 1 0   0 00000000 0 0 0
# hardware-loop jump with an empty FIFO, delayed flush
1 0 00000000 0 00000000 1 0 1 0   1 00006004 0 0 1
1 0 00000000 0 00000000 1 0 1 0   1 00006008 0 0 1
1 0 00000000 0 00000000 1 0 1 0   1 0000600c 0 0 1
1 0 00000000 1 00007000 1 0 1 0   1 00007000 0 0 1
1 0 00000000 0 00000000 1 1 1 0   0 00000000 1 0 1
1 0 00000000 0 00000000 1 1 1 0   1 00007004 0 0 1
1 0 00000000 0 00000000 0 1 1 0   1 00007008 0 0 1
0 0 00000000 0 00000000 0 1 0 0   0 00000000 1 8 1
0 0 00000000 0 00000000 0 1 1 1   0 00000000 1 c 1
0 0 00000000 0 00000000 0 0 1 1   0 00000000 1 4 0
0 0 00000000 0 00000000 0 0 1 0   0 00000000 0 0 0
# armed delayed flush cancelled by a branch
1 0 00000000 0 00000000 1 0 1 0   1 00007008 0 0 1
1 0 00000000 1 00008000 0 0 1 0   1 00008000 0 0 1
1 1 00009001 0 00000000 1 0 1 0   1 00009000 0 2 1
0 0 00000000 0 00000000 1 1 1 0   0 00000000 0 0 1
0 0 00000000 0 00000000 1 1 1 0   0 00000000 1 0 1
0 0 00000000 0 00000000 0 0 1 0   0 00000000 0 0 0

// ==== prefetch_ctrl_top.f ====
+incdir+.
pf_pkg.sv
pf_trans_issue.sv
pf_resp_flush_ctrl.sv
prefetch_ctrl_top.sv
pf_checker.sv
prefetch_ctrl_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns -j 0
TOP       = prefetch_ctrl_tb
FILELIST  = prefetch_ctrl_top.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, run, and fail unless the pass line appears in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
